/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = emailbox_tb
FILELIST = emailbox.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "available targets:"
	@echo "  help   show this list"
	@echo "  test   build with $(TOOL), run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^Result: PASSED$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

/* common/emailbox_defines.svh */
/*
 sizing and addressing macros for the mesh mailbox
 include wherever a width, the queue depth or the link id is needed
*/
`ifndef EMAILBOX_DEFINES_SVH
`define EMAILBOX_DEFINES_SVH

// mesh packet width in bits
`define MBOX_PW     104

// register index width, the bus address adds two byte-offset bits
`define MBOX_RFAW   6

// queue entries
`define MBOX_DEPTH  16

`define MBOX_ID     12'h000   // link id, matched against addr[31:20]
`define MBOX_GROUP  3'h3      // mailbox register group, addr[10:8]

`endif

/* common/emesh_pkg.sv */
/*
 mesh packet layout shared by the write decoder and the testbench
 import where a packet has to be split or built
*/
`default_nettype none

package emesh_pkg;

   // ##################################################
   // command encoding
   // ##################################################
   typedef enum logic {
      cmd_read  = 1'b0,   // packet bit 1 low
      cmd_write = 1'b1
   } emesh_cmd_e;

   // ##################################################
   // field positions in the 104-bit packet
   // ##################################################
   localparam int EMESH_ADDR_MSB = 39;   // 32-bit destination address
   localparam int EMESH_ADDR_LSB = 8;

   localparam int EMESH_DATA_MSB = 103;  // 64-bit payload
   localparam int EMESH_DATA_LSB = 40;

   localparam int EMESH_CMD_BIT  = 1;    // write/read select

   // derived widths
   localparam int EMESH_AW = EMESH_ADDR_MSB - EMESH_ADDR_LSB + 1;
   localparam int EMESH_DW = EMESH_DATA_MSB - EMESH_DATA_LSB + 1;

endpackage

`default_nettype wire

/* common/mailbox_regs_pkg.sv */
/*
 register indices of the mailbox group
 the index is mi_addr without its two byte-offset bits
*/
`default_nettype none

`include "emailbox_defines.svh"

package mailbox_regs_pkg;

   // ##################################################
   // register map
   // ##################################################
   // only two registers live here, other indices read as zero
   typedef enum logic [`MBOX_RFAW-1:0] {
      reg_mailbox_lo = `MBOX_RFAW'd9,    // peek at head message
      reg_mailbox_hi = `MBOX_RFAW'd10    // read head and pop it
   } mbox_reg_e;

   // true for the two readable mailbox registers
   function automatic logic is_mailbox_reg(input mbox_reg_e idx);
      logic hit;
      hit = (idx == reg_mailbox_lo) || (idx == reg_mailbox_hi);
      return hit;
   endfunction

endpackage

`default_nettype wire

/* emailbox.f */
+incdir+common
common/emesh_pkg.sv
common/mailbox_regs_pkg.sv
source/emesh_write_decoder.sv
source/mi_read_decoder.sv
mailbox/mailbox_queue.sv
mailbox/emailbox.sv
test/emailbox_tb.sv

/* mailbox/emailbox.sv */
/*
 mesh mailbox top level
 mesh writes to mailbox-low land in the queue, the processor reads
 them back through mailbox-low (peek) and mailbox-high (pop)
 connect mailbox_not_empty to an interrupt input
*/
`timescale 1ns/10ps
`default_nettype none

`include "emailbox_defines.svh"

module emailbox
   import mailbox_regs_pkg::*;
(
   input  logic                   rd_clk,
   input  logic                   reset,             // sync, active high

   // mesh write side
   input  logic                   emesh_access,
   input  logic [`MBOX_PW-1:0]    emesh_packet,

   // register read side
   input  logic                   mi_en,
   input  logic                   mi_we,
   input  logic [`MBOX_RFAW+1:0]  mi_addr,
   output logic [63:0]            mi_dout,

   // status levels
   output logic                   mailbox_full,
   output logic                   mailbox_not_empty
);

   // ##################################################
   // decoder to queue wiring
   // ##################################################
   logic         push;
   logic [63:0]  push_data;
   logic         rd_valid;
   mbox_reg_e    rd_sel;
   logic         pop;

   // mesh side filter
   emesh_write_decoder write_decoder_i (
      .rd_clk        (rd_clk),
      .reset         (reset),
      .emesh_access  (emesh_access),
      .emesh_packet  (emesh_packet),
      .push          (push),
      .push_data     (push_data)
   );

   // register side decode
   mi_read_decoder read_decoder_i (
      .rd_clk    (rd_clk),
      .reset     (reset),
      .mi_en     (mi_en),
      .mi_we     (mi_we),
      .mi_addr   (mi_addr),
      .rd_valid  (rd_valid),
      .rd_sel    (rd_sel),
      .pop       (pop)
   );

   // store, flags and read data
   mailbox_queue queue_i (
      .rd_clk             (rd_clk),
      .reset              (reset),
      .push               (push),
      .push_data          (push_data),
      .rd_valid           (rd_valid),
      .rd_sel             (rd_sel),
      .pop                (pop),
      .mi_dout            (mi_dout),
      .mailbox_full       (mailbox_full),
      .mailbox_not_empty  (mailbox_not_empty)
   );

endmodule

`default_nettype wire

/* mailbox/mailbox_queue.sv */
/*
 16-entry single-clock message queue with the mi_dout register
 push writes the tail, a mailbox-high read pops the head
 full and not-empty come straight from the occupancy count
*/
`timescale 1ns/10ps
`default_nettype none

`include "emailbox_defines.svh"

module mailbox_queue
   import mailbox_regs_pkg::*;
(
   input  logic         rd_clk,
   input  logic         reset,
   input  logic         push,               // from write decoder
   input  logic [63:0]  push_data,
   input  logic         rd_valid,           // from read decoder
   input  mbox_reg_e    rd_sel,
   input  logic         pop,
   output logic [63:0]  mi_dout,            // one cycle per read, else zero
   output logic         mailbox_full,
   output logic         mailbox_not_empty   // interrupt level
);

   localparam int PTR_W = $clog2(`MBOX_DEPTH);
   localparam int CNT_W = PTR_W + 1;        // must hold DEPTH itself

   // ##################################################
   // storage and pointers
   // ##################################################
   logic [63:0]       mem [`MBOX_DEPTH];
   logic [PTR_W-1:0]  wr_ptr;               // next free slot
   logic [PTR_W-1:0]  rd_ptr;               // head slot
   logic [CNT_W-1:0]  count;                // entries held
   logic              do_push;
   logic              do_pop;
   logic              rd_hit;

   assign mailbox_full      = (count == CNT_W'(`MBOX_DEPTH));
   assign mailbox_not_empty = (count != '0);

   assign do_push = push && !mailbox_full;       // overflow dropped
   assign do_pop  = pop && mailbox_not_empty;    // underflow ignored

   // peek or pop of a non-empty queue returns the head
   assign rd_hit = rd_valid && is_mailbox_reg(rd_sel) && mailbox_not_empty;

   // message store
   always_ff @(posedge rd_clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   // pointers wrap naturally at DEPTH (power of two)
   always_ff @(posedge rd_clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // occupancy
   always_ff @(posedge rd_clk) begin
      if (reset) begin
         count <= '0;
      end else begin
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;           // idle or both at once
         endcase
      end
   end

   // ##################################################
   // read data register
   // ##################################################
   always_ff @(posedge rd_clk) begin
      if (reset) begin
         mi_dout <= '0;
      end else if (rd_hit) begin
         mi_dout <= mem[rd_ptr];                // head before any pop
      end else begin
         mi_dout <= '0;                         // idle, other reg, or empty
      end
   end

   // ##################################################
   // checks
   // ##################################################
   // the sender owns flow control
   a_no_push_when_full : assert property (
      @(posedge rd_clk) disable iff (reset)
      push |-> !mailbox_full
   ) else $error("push while mailbox full, message dropped");

   a_count_in_range : assert property (
      @(posedge rd_clk) disable iff (reset)
      count <= CNT_W'(`MBOX_DEPTH)
   ) else $error("occupancy beyond depth");

   // full must never coexist with empty
   a_flags_consistent : assert property (
      @(posedge rd_clk) disable iff (reset)
      mailbox_full |-> mailbox_not_empty
   ) else $error("full and empty at once");

endmodule

`default_nettype wire

/* source/emesh_write_decoder.sv */
/*
 mesh write filter for the mailbox
 takes every incoming packet and raises a one-cycle push with the payload
 one cycle later when the packet is a write to the mailbox-low register
*/
`timescale 1ns/10ps
`default_nettype none

`include "emailbox_defines.svh"

module emesh_write_decoder
   import emesh_pkg::*;
   import mailbox_regs_pkg::*;
(
   input  logic                 rd_clk,
   input  logic                 reset,
   input  logic                 emesh_access,   // one-cycle strobe
   input  logic [`MBOX_PW-1:0]  emesh_packet,   // valid with the strobe
   output logic                 push,           // registered accept
   output logic [63:0]          push_data       // registered payload
);

   // ##################################################
   // packet fields
   // ##################################################
   emesh_cmd_e           pkt_cmd;
   logic [EMESH_AW-1:0]  pkt_addr;
   logic [EMESH_DW-1:0]  pkt_data;
   mbox_reg_e            pkt_reg;
   logic                 accept;

   assign pkt_cmd  = emesh_cmd_e'(emesh_packet[EMESH_CMD_BIT]);
   assign pkt_addr = emesh_packet[EMESH_ADDR_MSB:EMESH_ADDR_LSB];
   assign pkt_data = emesh_packet[EMESH_DATA_MSB:EMESH_DATA_LSB];
   assign pkt_reg  = mbox_reg_e'(pkt_addr[`MBOX_RFAW+1:2]);   // drop byte offset

   // all four must hold
   assign accept = emesh_access &&
                   (pkt_cmd == cmd_write) &&
                   (pkt_addr[31:20] == `MBOX_ID) &&      // our link
                   (pkt_addr[10:8] == `MBOX_GROUP) &&    // mailbox group
                   (pkt_reg == reg_mailbox_lo);

   // ##################################################
   // output stage
   // ##################################################
   always_ff @(posedge rd_clk) begin
      if (reset) begin
         push <= 1'b0;
      end else begin
         push <= accept;
      end
   end

   // payload follows the packet, qualified by push
   always_ff @(posedge rd_clk) begin
      push_data <= pkt_data;
   end

   // the queue stores whatever arrives with push
   a_push_data_known : assert property (
      @(posedge rd_clk) disable iff (reset)
      push |-> !$isunknown(push_data)
   ) else $error("push with unknown payload");

endmodule

`default_nettype wire

/* source/mi_read_decoder.sv */
/*
 register bus read decoder
 samples mi_en/mi_we/mi_addr and presents a registered read strobe,
 the register index and a pop for mailbox-high reads to the queue
*/
`timescale 1ns/10ps
`default_nettype none

`include "emailbox_defines.svh"

module mi_read_decoder
   import mailbox_regs_pkg::*;
(
   input  logic                   rd_clk,
   input  logic                   reset,
   input  logic                   mi_en,
   input  logic                   mi_we,     // writes are ignored here
   input  logic [`MBOX_RFAW+1:0]  mi_addr,   // byte address
   output logic                   rd_valid,  // read sampled last edge
   output mbox_reg_e              rd_sel,    // index of that read
   output logic                   pop        // read hit mailbox-high
);

   logic       mi_rd;
   mbox_reg_e  mi_reg;

   // ##################################################
   // decode
   // ##################################################
   assign mi_rd  = mi_en & ~mi_we;                       // enable without write
   assign mi_reg = mbox_reg_e'(mi_addr[`MBOX_RFAW+1:2]); // word index

   // strobes are control state
   always_ff @(posedge rd_clk) begin
      if (reset) begin
         rd_valid <= 1'b0;
         pop      <= 1'b0;
      end else begin
         rd_valid <= mi_rd;
         pop      <= mi_rd && (mi_reg == reg_mailbox_hi);  // only hi pops
      end
   end

   // select only matters while rd_valid is high
   always_ff @(posedge rd_clk) begin
      rd_sel <= mi_reg;
   end

   // ##################################################
   // checks
   // ##################################################
   // a pop without a read would lose a message unseen
   a_pop_is_read : assert property (
      @(posedge rd_clk) disable iff (reset)
      pop |-> (rd_valid && (rd_sel == reg_mailbox_hi))
   ) else $error("pop without a mailbox-high read");

endmodule

`default_nettype wire

/* test/emailbox_tb.sv */
/*
 self-checking testbench for the mesh mailbox
 a reference queue follows the push, drop, peek and pop rules, and
 concurrent assertions compare mi_dout and both flags with it every edge
*/
`timescale 1ns/10ps
`default_nettype none

`include "emailbox_defines.svh"

module emailbox_tb
   import emesh_pkg::*;
   import mailbox_regs_pkg::*;
();

   localparam int CLK_PERIOD    = 100;
   localparam int TEST_CYCLES   = 180;   // all phases below, rounded up
   localparam int MARGIN_CYCLES = 50;

   logic                   rd_clk = 1'b0;
   logic                   reset  = 1'b1;
   logic                   emesh_access;
   logic [`MBOX_PW-1:0]    emesh_packet;
   logic                   mi_en;
   logic                   mi_we;
   logic [`MBOX_RFAW+1:0]  mi_addr;
   logic [63:0]            mi_dout;
   logic                   mailbox_full;
   logic                   mailbox_not_empty;

   int mismatch_count = 0;
   int other_count    = 0;

   // ##################################################
   // reference model
   // ##################################################
   logic [63:0]            model_q [$];    // expected contents, head first
   logic                   pend_push;      // accepted packet, one edge old
   logic [63:0]            pend_data;
   logic                   pend_rd;        // read sampled last edge
   logic [`MBOX_RFAW-1:0]  pend_sel;
   logic                   pend_pop;
   logic [63:0]            exp_dout;
   logic                   exp_full;
   logic                   exp_not_empty;

   always #(CLK_PERIOD/2) rd_clk = ~rd_clk;

   emailbox emailbox_i (
      .rd_clk             (rd_clk),
      .reset              (reset),
      .emesh_access       (emesh_access),
      .emesh_packet       (emesh_packet),
      .mi_en              (mi_en),
      .mi_we              (mi_we),
      .mi_addr            (mi_addr),
      .mi_dout            (mi_dout),
      .mailbox_full       (mailbox_full),
      .mailbox_not_empty  (mailbox_not_empty)
   );

   always @(posedge rd_clk) begin
      logic [31:0] addr;
      logic        push_ok;
      logic        pop_ok;
      addr = emesh_packet[EMESH_ADDR_MSB:EMESH_ADDR_LSB];
      if (reset) begin
         model_q.delete();
         pend_push     <= 1'b0;
         pend_rd       <= 1'b0;
         pend_pop      <= 1'b0;
         exp_dout      <= '0;
         exp_full      <= 1'b0;
         exp_not_empty <= 1'b0;
      end else begin
         // queue stage, acts on last edge's requests
         if (pend_rd && (pend_sel == reg_mailbox_lo || pend_sel == reg_mailbox_hi) &&
             model_q.size() > 0) begin
            exp_dout <= model_q[0];              // head before the pop
         end else begin
            exp_dout <= '0;
         end
         push_ok = pend_push && (model_q.size() < `MBOX_DEPTH);   // drop when full
         pop_ok  = pend_pop && (model_q.size() > 0);              // ignore when empty
         if (pop_ok) begin
            void'(model_q.pop_front());
         end
         if (push_ok) begin
            model_q.push_back(pend_data);
         end
         exp_full      <= (model_q.size() == `MBOX_DEPTH);
         exp_not_empty <= (model_q.size() != 0);
         // decoder stage, filter rule straight from the packet fields
         pend_push <= emesh_access && (emesh_packet[EMESH_CMD_BIT] == cmd_write) &&
                      (addr[31:20] == `MBOX_ID) && (addr[10:8] == `MBOX_GROUP) &&
                      (addr[7:2] == reg_mailbox_lo);
         pend_data <= emesh_packet[EMESH_DATA_MSB:EMESH_DATA_LSB];
         pend_rd   <= mi_en && !mi_we;
         pend_sel  <= mi_addr[`MBOX_RFAW+1:2];
         pend_pop  <= mi_en && !mi_we && (mi_addr[`MBOX_RFAW+1:2] == reg_mailbox_hi);
      end
   end

   // ##################################################
   // checks
   // ##################################################
   a_dout_matches : assert property (
      @(posedge rd_clk) disable iff (reset) mi_dout == exp_dout
   ) else begin
      mismatch_count++;
      $display("MISMATCH mi_dout expected %h actual %h", $sampled(exp_dout), $sampled(mi_dout));
   end

   a_full_matches : assert property (
      @(posedge rd_clk) disable iff (reset) mailbox_full == exp_full
   ) else begin
      mismatch_count++;
      $display("MISMATCH mailbox_full expected %h actual %h",
               $sampled(exp_full), $sampled(mailbox_full));
   end

   a_not_empty_matches : assert property (
      @(posedge rd_clk) disable iff (reset) mailbox_not_empty == exp_not_empty
   ) else begin
      mismatch_count++;
      $display("MISMATCH mailbox_not_empty expected %h actual %h",
               $sampled(exp_not_empty), $sampled(mailbox_not_empty));
   end

   // first edge after reset sees cleared outputs
   a_reset_clears : assert property (
      @(posedge rd_clk) $fell(reset) |-> (mi_dout == '0 && !mailbox_full && !mailbox_not_empty)
   ) else begin
      other_count++;
      $display("outputs were not cleared by reset");
   end

   // ##################################################
   // stimulus
   // ##################################################
   function automatic logic [`MBOX_PW-1:0] make_packet(input emesh_cmd_e cmd,
         input logic [11:0] link, input logic [2:0] group,
         input logic [`MBOX_RFAW-1:0] idx, input logic [63:0] data);
      logic [`MBOX_PW-1:0] pkt;
      logic [31:0]         addr;
      pkt         = '0;
      addr        = '0;
      addr[31:20] = link;
      addr[10:8]  = group;
      addr[7:2]   = idx;                    // byte offset stays zero
      pkt[EMESH_CMD_BIT] = cmd;
      pkt[EMESH_ADDR_MSB:EMESH_ADDR_LSB] = addr;
      pkt[EMESH_DATA_MSB:EMESH_DATA_LSB] = data;
      return pkt;
   endfunction

   // one cycle of inputs, held until the next call
   task automatic drive(input logic acc, input logic [`MBOX_PW-1:0] pkt,
         input logic en, input logic we, input logic [`MBOX_RFAW-1:0] idx);
      @(negedge rd_clk);
      emesh_access = acc;
      emesh_packet = pkt;
      mi_en        = en;
      mi_we        = we;
      mi_addr      = {idx, 2'b00};
   endtask

   function automatic logic [`MBOX_PW-1:0] good_packet();
      return make_packet(cmd_write, `MBOX_ID, `MBOX_GROUP, reg_mailbox_lo,
                         {$urandom, $urandom});
   endfunction

   task automatic write_msg();
      drive(1'b1, good_packet(), 1'b0, 1'b0, '0);
   endtask

   task automatic read_reg(input logic [`MBOX_RFAW-1:0] idx);
      drive(1'b0, '0, 1'b1, 1'b0, idx);
   endtask

   task automatic idle(input int n);
      repeat (n) drive(1'b0, '0, 1'b0, 1'b0, '0);
   endtask

   task automatic apply_reset(input int n);
      drive(1'b0, '0, 1'b0, 1'b0, '0);
      reset = 1'b1;
      repeat (n) @(negedge rd_clk);
      reset = 1'b0;
   endtask

   initial begin
      void'($urandom(32'hfaad));
      emesh_access = 1'b0;
      emesh_packet = '0;
      mi_en        = 1'b0;
      mi_we        = 1'b0;
      mi_addr      = '0;
      repeat (4) @(posedge rd_clk);
      @(negedge rd_clk);
      reset = 1'b0;

      // filtering, five rejects then one hit
      drive(1'b0, good_packet(), 1'b0, 1'b0, '0);           // no strobe
      drive(1'b1, make_packet(cmd_read, `MBOX_ID, `MBOX_GROUP, reg_mailbox_lo, 64'h1), 1'b0, 1'b0, '0);
      drive(1'b1, make_packet(cmd_write, `MBOX_ID ^ 12'h5a1, `MBOX_GROUP, reg_mailbox_lo, 64'h2),
            1'b0, 1'b0, '0);
      drive(1'b1, make_packet(cmd_write, `MBOX_ID, 3'h2, reg_mailbox_lo, 64'h3), 1'b0, 1'b0, '0);
      drive(1'b1, make_packet(cmd_write, `MBOX_ID, `MBOX_GROUP, reg_mailbox_hi, 64'h4),
            1'b0, 1'b0, '0);
      idle(3);
      read_reg(reg_mailbox_lo);
      read_reg(reg_mailbox_hi);
      idle(3);
      write_msg();
      idle(3);
      read_reg(reg_mailbox_hi);
      idle(2);

      // order and peek
      repeat (8) write_msg();
      idle(2);
      repeat (8) begin
         read_reg(reg_mailbox_lo);                         // peek
         read_reg(reg_mailbox_hi);                         // same value, then pop
      end
      idle(3);

      // full flag and drain
      repeat (`MBOX_DEPTH) write_msg();
      idle(3);
      read_reg(reg_mailbox_hi);
      idle(2);
      repeat (`MBOX_DEPTH - 1) read_reg(reg_mailbox_hi);
      idle(3);

      // zero reads with data waiting
      repeat (2) write_msg();
      idle(2);
      drive(1'b0, '0, 1'b1, 1'b1, reg_mailbox_lo);         // register writes
      drive(1'b0, '0, 1'b1, 1'b1, reg_mailbox_hi);
      read_reg(6'd0);
      read_reg(6'd8);
      read_reg(6'd11);
      read_reg(6'd63);
      repeat (2) read_reg(reg_mailbox_hi);
      idle(2);
      read_reg(reg_mailbox_lo);                            // empty queue
      read_reg(reg_mailbox_hi);
      idle(2);
      repeat (2) write_msg();
      idle(2);
      repeat (2) read_reg(reg_mailbox_hi);
      idle(3);

      // push and pop in the same cycle
      repeat (3) write_msg();
      idle(2);
      repeat (6) drive(1'b1, good_packet(), 1'b1, 1'b0, reg_mailbox_hi);
      idle(2);
      repeat (3) read_reg(reg_mailbox_hi);
      idle(3);

      // mid-run reset
      repeat (4) write_msg();
      idle(2);
      apply_reset(2);
      idle(2);
      read_reg(reg_mailbox_hi);
      read_reg(reg_mailbox_lo);
      idle(4);

      $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
      if (mismatch_count == 0 && other_count == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

   // stops a hung run
   initial begin
      #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
      $display("watchdog expired before the tests finished");
      $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
      $display("Result: FAILED");
      $finish;
   end

endmodule

`default_nettype wire
